// File: all.f
+incdir+src
src/tap_fsm_pkg.sv
src/tap_reg_pkg.sv
src/tap_fsm.sv
src/tap_ir.sv
src/tap_data_reg.sv
src/tap_tdo_mux.sv
src/jtag_tap.sv
tests/tap_checker.sv
tests/tap_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the TAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tap_tb -o tap_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tap_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
exit 1

// File: src/jtag_tap.sv
/*
 * JTAG TAP controller, top level
 * FSM, instruction register, internal data registers and TDO stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "tap_config.svh"

module jtag_tap (
    input  wire logic                 tck,
    input  wire logic                 trst_n,
    input  wire logic                 tms,
    input  wire logic                 tdi,
    input  wire tap_reg_pkg::idcode_t fuse_idcode,
    input  wire logic                 dmi_ch_tdo,
    output logic                      tdo,
    output logic                      tdo_en,        // TDO buffer enable
    output tap_reg_pkg::dmi_chain_t   dmi_chain
);

    tap_fsm_pkg::tap_state_e tap_state;
    tap_fsm_pkg::tap_ctrl_t  tap_ctrl;
    logic                    sync_rst_n;
    logic                    ir_lsb;
    logic                    dmi_active;
    tap_reg_pkg::dr_sel_t    dr_sel;
    tap_reg_pkg::dr_sel_t    dr_tdo;

    tap_fsm tap_fsm_inst (
        .tck        (tck),
        .trst_n     (trst_n),
        .tms        (tms),
        .tap_state  (tap_state),
        .tap_ctrl   (tap_ctrl),
        .sync_rst_n (sync_rst_n)
    );

    tap_ir tap_ir_inst (
        .tck        (tck),
        .trst_n     (trst_n),
        .sync_rst_n (sync_rst_n),
        .tdi        (tdi),
        .tap_state  (tap_state),
        .tap_ctrl   (tap_ctrl),
        .ir_lsb     (ir_lsb),
        .dr_sel     (dr_sel),
        .dmi_active (dmi_active),
        .dmi_chain  (dmi_chain)
    );

    // ------------------------------------------------------------------
    // Internal data registers, sized by index
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `TAP_NUM_DR; i++) begin : g_dr
        localparam int DR_WIDTH = (i == `TAP_DR_BYPASS) ? 1 :
                                  (i == `TAP_DR_IDCODE) ? `TAP_IDCODE_WIDTH :
                                                          `TAP_BLD_ID_WIDTH;
        logic [DR_WIDTH-1:0] capture_value;

        if (i == `TAP_DR_BYPASS) begin : g_bypass
            assign capture_value = '0;           // BYPASS captures 0
        end else if (i == `TAP_DR_IDCODE) begin : g_idcode
            assign capture_value = fuse_idcode;
        end else begin : g_bld_id
            assign capture_value = `TAP_BLD_ID_VALUE;
        end

        tap_data_reg #(
            .WIDTH (DR_WIDTH)
        ) dr_inst (
            .tck           (tck),
            .trst_n        (trst_n),
            .sync_rst_n    (sync_rst_n),
            .sel           (dr_sel[i]),
            .tap_ctrl      (tap_ctrl),
            .tdi           (tdi),
            .capture_value (capture_value),
            .tdo           (dr_tdo[i])
        );
    end

    tap_tdo_mux tap_tdo_mux_inst (
        .tck        (tck),
        .trst_n     (trst_n),
        .sync_rst_n (sync_rst_n),
        .tap_ctrl   (tap_ctrl),
        .dr_sel     (dr_sel),
        .dr_tdo     (dr_tdo),
        .dmi_active (dmi_active),
        .dmi_ch_tdo (dmi_ch_tdo),
        .ir_lsb     (ir_lsb),
        .tdo        (tdo),
        .tdo_en     (tdo_en)
    );

endmodule : jtag_tap

`default_nettype wire

// File: src/tap_config.svh
/*
 * JTAG TAP configuration
 * Register widths, data register indices, instruction codes, build ID
 */
`ifndef TAP_CONFIG_SVH
`define TAP_CONFIG_SVH

// Register widths
`define TAP_IR_WIDTH          5
`define TAP_IDCODE_WIDTH      32
`define TAP_BLD_ID_WIDTH      32
`define TAP_BLD_ID_VALUE      32'h1905_2201   // Fixed build identifier

// Internal data registers, index into the generate loop
`define TAP_NUM_DR            3
`define TAP_DR_BYPASS         0
`define TAP_DR_IDCODE         1
`define TAP_DR_BLD_ID         2

// Instruction codes
`define TAP_INSTR_IDCODE      5'h01
`define TAP_INSTR_BLD_ID      5'h04
`define TAP_INSTR_DTMCS       5'h10
`define TAP_INSTR_DMI_ACCESS  5'h11
`define TAP_INSTR_BYPASS      5'h1F

`define TAP_DMI_CH_ID_WIDTH   2     // Debug chain identifier

`endif

// File: src/tap_data_reg.sv
/*
 * TAP data register
 * Parallel capture, right shift from TDI, serial out from bit 0
 */
`timescale 1ns/1ps
`default_nettype none

module tap_data_reg #(
    parameter int WIDTH = 32
) (
    input  wire logic                   tck,
    input  wire logic                   trst_n,
    input  wire logic                   sync_rst_n,
    input  wire logic                   sel,            // Chosen by the IR decode
    input  wire tap_fsm_pkg::tap_ctrl_t tap_ctrl,
    input  wire logic                   tdi,
    input  wire logic [WIDTH-1:0]       capture_value,
    output logic                        tdo
);

    logic [WIDTH-1:0] dr_q;
    logic [WIDTH:0]   shift_in;    // TDI on top of the current value

    assign shift_in = {tdi, dr_q};

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            dr_q <= '0;
        end else if (!sync_rst_n) begin
            dr_q <= '0;
        end else if (sel && tap_ctrl.dr_capture) begin
            dr_q <= capture_value;
        end else if (sel && tap_ctrl.dr_shift) begin
            dr_q <= shift_in[WIDTH:1];      // Also covers WIDTH of 1
        end
    end

    assign tdo = dr_q[0];

endmodule : tap_data_reg

`default_nettype wire

// File: src/tap_fsm.sv
/*
 * TAP state machine
 * Sixteen-state TMS sequencer, internal reset and registered strobes
 */
`timescale 1ns/1ps
`default_nettype none

module tap_fsm (
    input  wire logic              tck,
    input  wire logic              trst_n,
    input  wire logic              tms,
    output tap_fsm_pkg::tap_state_e tap_state,
    output tap_fsm_pkg::tap_ctrl_t  tap_ctrl,
    output logic                   sync_rst_n   // Low while in Test-Logic-Reset
);

    tap_fsm_pkg::tap_state_e state_next;

    // ------------------------------------------------------------------
    // State register and transition table
    // ------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tap_state <= tap_fsm_pkg::TAP_RESET;
        end else begin
            tap_state <= state_next;
        end
    end

    always_comb begin
        case (tap_state)
            tap_fsm_pkg::TAP_RESET:
                state_next = tms ? tap_fsm_pkg::TAP_RESET : tap_fsm_pkg::TAP_IDLE;
            tap_fsm_pkg::TAP_IDLE:
                state_next = tms ? tap_fsm_pkg::TAP_DR_SELECT : tap_fsm_pkg::TAP_IDLE;
            tap_fsm_pkg::TAP_DR_SELECT:
                state_next = tms ? tap_fsm_pkg::TAP_IR_SELECT : tap_fsm_pkg::TAP_DR_CAPTURE;
            tap_fsm_pkg::TAP_DR_CAPTURE:
                state_next = tms ? tap_fsm_pkg::TAP_DR_EXIT1 : tap_fsm_pkg::TAP_DR_SHIFT;
            tap_fsm_pkg::TAP_DR_SHIFT:
                state_next = tms ? tap_fsm_pkg::TAP_DR_EXIT1 : tap_fsm_pkg::TAP_DR_SHIFT;
            tap_fsm_pkg::TAP_DR_EXIT1:
                state_next = tms ? tap_fsm_pkg::TAP_DR_UPDATE : tap_fsm_pkg::TAP_DR_PAUSE;
            tap_fsm_pkg::TAP_DR_PAUSE:
                state_next = tms ? tap_fsm_pkg::TAP_DR_EXIT2 : tap_fsm_pkg::TAP_DR_PAUSE;
            tap_fsm_pkg::TAP_DR_EXIT2:
                state_next = tms ? tap_fsm_pkg::TAP_DR_UPDATE : tap_fsm_pkg::TAP_DR_SHIFT;
            tap_fsm_pkg::TAP_DR_UPDATE:
                state_next = tms ? tap_fsm_pkg::TAP_DR_SELECT : tap_fsm_pkg::TAP_IDLE;
            tap_fsm_pkg::TAP_IR_SELECT:
                state_next = tms ? tap_fsm_pkg::TAP_RESET : tap_fsm_pkg::TAP_IR_CAPTURE;
            tap_fsm_pkg::TAP_IR_CAPTURE:
                state_next = tms ? tap_fsm_pkg::TAP_IR_EXIT1 : tap_fsm_pkg::TAP_IR_SHIFT;
            tap_fsm_pkg::TAP_IR_SHIFT:
                state_next = tms ? tap_fsm_pkg::TAP_IR_EXIT1 : tap_fsm_pkg::TAP_IR_SHIFT;
            tap_fsm_pkg::TAP_IR_EXIT1:
                state_next = tms ? tap_fsm_pkg::TAP_IR_UPDATE : tap_fsm_pkg::TAP_IR_PAUSE;
            tap_fsm_pkg::TAP_IR_PAUSE:
                state_next = tms ? tap_fsm_pkg::TAP_IR_EXIT2 : tap_fsm_pkg::TAP_IR_PAUSE;
            tap_fsm_pkg::TAP_IR_EXIT2:
                state_next = tms ? tap_fsm_pkg::TAP_IR_UPDATE : tap_fsm_pkg::TAP_IR_SHIFT;
            tap_fsm_pkg::TAP_IR_UPDATE:
                state_next = tms ? tap_fsm_pkg::TAP_DR_SELECT : tap_fsm_pkg::TAP_IDLE;
        endcase
    end

    // Internal reset, dropped half a cycle into Test-Logic-Reset
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            sync_rst_n <= 1'b0;
        end else begin
            sync_rst_n <= (tap_state != tap_fsm_pkg::TAP_RESET);
        end
    end

    // ------------------------------------------------------------------
    // Control strobes, registered from the state being entered
    // ------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tap_ctrl <= '0;
        end else begin
            tap_ctrl.ir_shift   <= sync_rst_n & (state_next == tap_fsm_pkg::TAP_IR_SHIFT);
            tap_ctrl.dr_capture <= sync_rst_n & (state_next == tap_fsm_pkg::TAP_DR_CAPTURE);
            tap_ctrl.dr_shift   <= sync_rst_n & (state_next == tap_fsm_pkg::TAP_DR_SHIFT);
            tap_ctrl.dr_update  <= sync_rst_n & (state_next == tap_fsm_pkg::TAP_DR_UPDATE);
        end
    end

    // TMS steers every transition, so it must be driven once out of reset
    tms_known_a: assert property (@(posedge tck) disable iff (!trst_n) !$isunknown(tms))
        else $error("tap_fsm: tms unknown");

endmodule : tap_fsm

`default_nettype wire

// File: src/tap_fsm_pkg.sv
/*
 * TAP state machine types
 * Sixteen-state encoding and the registered control strobes
 */
`default_nettype none

package tap_fsm_pkg;

    typedef enum logic [3:0] {
        TAP_RESET      = 4'h0,  // Test-Logic-Reset
        TAP_IDLE       = 4'h1,  // Run-Test/Idle
        TAP_DR_SELECT  = 4'h2,
        TAP_DR_CAPTURE = 4'h3,
        TAP_DR_SHIFT   = 4'h4,
        TAP_DR_EXIT1   = 4'h5,
        TAP_DR_PAUSE   = 4'h6,
        TAP_DR_EXIT2   = 4'h7,
        TAP_DR_UPDATE  = 4'h8,
        TAP_IR_SELECT  = 4'h9,
        TAP_IR_CAPTURE = 4'hA,
        TAP_IR_SHIFT   = 4'hB,
        TAP_IR_EXIT1   = 4'hC,
        TAP_IR_PAUSE   = 4'hD,
        TAP_IR_EXIT2   = 4'hE,
        TAP_IR_UPDATE  = 4'hF
    } tap_state_e;

    // Strobes, each high for the cycles of its state
    typedef struct packed {
        logic ir_shift;
        logic dr_capture;
        logic dr_shift;
        logic dr_update;
    } tap_ctrl_t;

endpackage : tap_fsm_pkg

`default_nettype wire

// File: src/tap_ir.sv
/*
 * TAP instruction register
 * Shift and hold stages plus the decode to data registers and debug chain
 */
`timescale 1ns/1ps
`default_nettype none

`include "tap_config.svh"

module tap_ir (
    input  wire logic                    tck,
    input  wire logic                    trst_n,
    input  wire logic                    sync_rst_n,
    input  wire logic                    tdi,
    input  wire tap_fsm_pkg::tap_state_e tap_state,
    input  wire tap_fsm_pkg::tap_ctrl_t  tap_ctrl,
    output logic                         ir_lsb,      // Serial out during Shift-IR
    output tap_reg_pkg::dr_sel_t         dr_sel,
    output logic                         dmi_active,  // Debug chain owns the DR path
    output tap_reg_pkg::dmi_chain_t      dmi_chain
);

    tap_reg_pkg::tap_ir_t    ir_shift_q;   // Shift stage
    tap_reg_pkg::tap_ir_t    ir_hold_q;    // Current instruction
    tap_reg_pkg::dmi_ch_id_t ch_id;

    // Capture 00001, then shift TDI in from the top
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_shift_q <= '0;
        end else if (!sync_rst_n) begin
            ir_shift_q <= '0;
        end else if (tap_state == tap_fsm_pkg::TAP_IR_CAPTURE) begin
            ir_shift_q <= tap_reg_pkg::tap_ir_t'(1);
        end else if (tap_ctrl.ir_shift) begin
            ir_shift_q <= {tdi, ir_shift_q[`TAP_IR_WIDTH-1:1]};
        end
    end

    assign ir_lsb = ir_shift_q[0];

    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_hold_q <= tap_reg_pkg::INSTR_IDCODE;
        end else if (!sync_rst_n) begin
            ir_hold_q <= tap_reg_pkg::INSTR_IDCODE;   // Default after TMS reset
        end else if (tap_state == tap_fsm_pkg::TAP_IR_UPDATE) begin
            ir_hold_q <= ir_shift_q;
        end
    end

    // ------------------------------------------------------------------
    // Instruction decode
    // ------------------------------------------------------------------
    always_comb begin
        dr_sel     = '0;
        dmi_active = 1'b0;
        ch_id      = '0;
        case (ir_hold_q)
            tap_reg_pkg::INSTR_IDCODE: dr_sel[`TAP_DR_IDCODE] = 1'b1;
            tap_reg_pkg::INSTR_BLD_ID: dr_sel[`TAP_DR_BLD_ID] = 1'b1;
            tap_reg_pkg::INSTR_DTMCS: begin
                dmi_active = 1'b1;
                ch_id      = tap_reg_pkg::dmi_ch_id_t'(1);
            end
            tap_reg_pkg::INSTR_DMI_ACCESS: begin
                dmi_active = 1'b1;
                ch_id      = tap_reg_pkg::dmi_ch_id_t'(2);
            end
            tap_reg_pkg::INSTR_BYPASS: dr_sel[`TAP_DR_BYPASS] = 1'b1;
            default:                   dr_sel[`TAP_DR_BYPASS] = 1'b1;  // Undefined codes
        endcase
    end

    // Chain sees the raw DR strobes, qualified by sel on its side
    assign dmi_chain = '{sel:     dmi_active,
                         id:      ch_id,
                         capture: tap_ctrl.dr_capture,
                         shift:   tap_ctrl.dr_shift,
                         update:  tap_ctrl.dr_update,
                         tdi:     tdi};

endmodule : tap_ir

`default_nettype wire

// File: src/tap_reg_pkg.sv
/*
 * TAP register types
 * Instruction codes, register vectors and the debug-chain bundle
 */
`default_nettype none

`include "tap_config.svh"

package tap_reg_pkg;

    typedef logic [`TAP_IR_WIDTH-1:0]        tap_ir_t;
    typedef logic [`TAP_IDCODE_WIDTH-1:0]    idcode_t;      // IDCODE and BLD_ID
    typedef logic [`TAP_NUM_DR-1:0]          dr_sel_t;      // One-hot over internal DRs
    typedef logic [`TAP_DMI_CH_ID_WIDTH-1:0] dmi_ch_id_t;

    typedef enum tap_ir_t {
        INSTR_IDCODE     = `TAP_INSTR_IDCODE,
        INSTR_BLD_ID     = `TAP_INSTR_BLD_ID,
        INSTR_DTMCS      = `TAP_INSTR_DTMCS,
        INSTR_DMI_ACCESS = `TAP_INSTR_DMI_ACCESS,
        INSTR_BYPASS     = `TAP_INSTR_BYPASS
    } tap_instr_e;

    // External debug-module scan chain
    typedef struct packed {
        logic       sel;        // Chain selected by the IR
        dmi_ch_id_t id;         // 1 for DTMCS, 2 for DMI_ACCESS
        logic       capture;
        logic       shift;
        logic       update;
        logic       tdi;
    } dmi_chain_t;

endpackage : tap_reg_pkg

`default_nettype wire

// File: src/tap_tdo_mux.sv
/*
 * TAP output stage
 * Selects the shifting register and drives TDO on the falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module tap_tdo_mux (
    input  wire logic                   tck,
    input  wire logic                   trst_n,
    input  wire logic                   sync_rst_n,
    input  wire tap_fsm_pkg::tap_ctrl_t tap_ctrl,
    input  wire tap_reg_pkg::dr_sel_t   dr_sel,
    input  wire tap_reg_pkg::dr_sel_t   dr_tdo,     // Serial bit of each DR
    input  wire logic                   dmi_active,
    input  wire logic                   dmi_ch_tdo,
    input  wire logic                   ir_lsb,
    output logic                        tdo,
    output logic                        tdo_en
);

    logic dr_bit;
    logic tdo_d;
    logic tdo_en_d;

    // One-hot select, so an OR of the masked bits is enough
    assign dr_bit = dmi_active ? dmi_ch_tdo : |(dr_sel & dr_tdo);

    always_comb begin
        tdo_d    = 1'b0;
        tdo_en_d = 1'b0;
        if (tap_ctrl.dr_shift) begin
            tdo_d    = dr_bit;
            tdo_en_d = 1'b1;
        end else if (tap_ctrl.ir_shift) begin
            tdo_d    = ir_lsb;
            tdo_en_d = 1'b1;
        end
    end

    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else if (!sync_rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= tdo_d;
            tdo_en <= tdo_en_d;
        end
    end

    // External chain must answer before TDO is registered
    dmi_tdo_known_a: assert property (@(negedge tck) disable iff (!trst_n)
        (tap_ctrl.dr_shift && dmi_active) |-> !$isunknown(dmi_ch_tdo))
        else $error("tap_tdo_mux: dmi_ch_tdo unknown during shift");

endmodule : tap_tdo_mux

`default_nettype wire

// File: tests/tap_checker.sv
/*
 * TAP scan checker
 * Collects TDO bits while tdo_en is high and compares them per scan
 */
`timescale 1ns/1ps
`default_nettype none

module tap_checker (
    input  wire logic         tck,
    input  wire logic         trst_n,
    input  wire logic         tdo,
    input  wire logic         tdo_en,
    input  wire logic         start,       // Arms one scan
    input  wire logic         check_en,    // Low for scans that are only drained
    input  wire logic [6:0]   exp_len,
    input  wire logic [63:0]  exp_val,
    input  wire logic [255:0] test_name,
    output logic              done,        // Set when the scan has been compared
    output int                error_count
);

    logic        armed;
    logic [6:0]  bit_cnt;
    logic [63:0] got;
    logic [63:0] mask;

    assign mask = (64'h1 << exp_len) - 64'h1;

    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            armed       <= 1'b0;
            bit_cnt     <= '0;
            got         <= '0;
            done        <= 1'b0;
            error_count <= 0;
        end else if (start) begin
            armed   <= 1'b1;
            bit_cnt <= '0;
            got     <= '0;
            done    <= 1'b0;
        end else if (armed && tdo_en) begin
            got[bit_cnt[5:0]] <= tdo;      // LSB leaves first
            bit_cnt           <= bit_cnt + 7'd1;
        end else if (armed && bit_cnt != 0) begin
            // Shift has ended
            armed <= 1'b0;
            done  <= 1'b1;
            if (check_en && bit_cnt != exp_len) begin
                $display("FAILED %0s bit count expected %0d actual %0d", test_name,
                         exp_len, bit_cnt);
                error_count <= error_count + 1;
            end else if (check_en && (got & mask) != (exp_val & mask)) begin
                $display("FAILED %0s expected %h actual %h", test_name,
                         exp_val & mask, got & mask);
                error_count <= error_count + 1;
            end
        end else if (!armed && tdo_en) begin
            $display("%0s: tdo_en high outside a shift", test_name);
            error_count <= error_count + 1;
        end
    end

endmodule : tap_checker

`default_nettype wire

// File: tests/tap_input.txt
# name op bits tdi expected, values in hex, sent and received LSB first
# op: IR code loaded first, - keeps the current IR, r resets from inside a DR shift
reset_idcode     -  32 00000000 DEADC0DE
idcode_loaded    01 32 FFFFFFFF DEADC0DE
bypass           1F 8  A5       4A
bypass_undef     07 8  3C       78
bld_id           04 32 00000000 19052201
bld_id_tdi       04 32 12345678 19052201
dtmcs            10 16 F0A5     0F5A
dmi_access       11 12 ABC      543
tms_reset        r  32 00000000 DEADC0DE
bypass_after     1F 4  6        C

// File: tests/tap_tb.sv
/*
 * JTAG TAP testbench
 * File-driven IR and DR scans, debug chain model, strobe counting
 */
`timescale 1ns/1ps
`default_nettype none

`include "tap_config.svh"

module tap_tb;

    logic                    tck;
    logic                    trst_n;
    logic                    tms;
    logic                    tdi;
    tap_reg_pkg::idcode_t    fuse_idcode;
    logic                    dmi_ch_tdo;
    logic                    tdo;
    logic                    tdo_en;
    tap_reg_pkg::dmi_chain_t dmi_chain;

    // Checker handshake
    logic         chk_start;
    logic         chk_en;
    logic [6:0]   chk_len;
    logic [63:0]  chk_exp;
    logic [255:0] chk_name;
    logic         chk_done;
    int           chk_errors;

    int tb_errors;
    int cap_cnt;
    int upd_cnt;
    int sft_cnt;

    jtag_tap jtag_tap_inst (
        .tck         (tck),
        .trst_n      (trst_n),
        .tms         (tms),
        .tdi         (tdi),
        .fuse_idcode (fuse_idcode),
        .dmi_ch_tdo  (dmi_ch_tdo),
        .tdo         (tdo),
        .tdo_en      (tdo_en),
        .dmi_chain   (dmi_chain)
    );

    tap_checker tap_checker_inst (
        .tck         (tck),
        .trst_n      (trst_n),
        .tdo         (tdo),
        .tdo_en      (tdo_en),
        .start       (chk_start),
        .check_en    (chk_en),
        .exp_len     (chk_len),
        .exp_val     (chk_exp),
        .test_name   (chk_name),
        .done        (chk_done),
        .error_count (chk_errors)
    );

    always #4 tck = ~tck;               // 8 ns period

    assign dmi_ch_tdo = ~dmi_chain.tdi;  // Debug chain model inverts its input

    // Chain strobes counted mid-cycle where they are stable
    always @(negedge tck) begin
        if (trst_n && dmi_chain.capture) cap_cnt++;
        if (trst_n && dmi_chain.update) upd_cnt++;
        if (trst_n && dmi_chain.shift) sft_cnt++;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("Errors: %0d (testbench %0d, checker %0d)",
                 tb_errors + chk_errors, tb_errors, chk_errors);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic step(input logic t, input logic d);
        @(posedge tck);
        tms <= t;
        tdi <= d;
    endtask

    task automatic compare_value(input logic [255:0] name, input string what,
                                 input logic [63:0] expv, input logic [63:0] actv);
        if (expv !== actv) begin
            $display("FAILED %0s %s expected %h actual %h", name, what, expv, actv);
            tb_errors++;
        end
    endtask

    task automatic arm_checker(input logic [255:0] name, input int len,
                               input logic [63:0] expv, input logic en);
        @(posedge tck);
        chk_name  <= name;
        chk_len   <= len[6:0];
        chk_exp   <= expv;
        chk_en    <= en;
        chk_start <= 1'b1;
        @(posedge tck);
        chk_start <= 1'b0;
    endtask

    task automatic wait_checker_done();
        int n;
        n = 0;
        while (!chk_done && n < 40) begin
            @(negedge tck);
            n++;
        end
        if (!chk_done) end_with_failure("Timeout waiting for the checker to finish a scan");
    endtask

    // Idle to Shift-IR, load code, back to Idle
    task automatic load_instruction(input logic [255:0] name, input logic [4:0] code);
        arm_checker(name, `TAP_IR_WIDTH, 64'h01, 1'b1);   // IR captures 00001
        step(1'b1, 1'b0);
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);
        for (int i = 0; i < `TAP_IR_WIDTH; i++) begin
            step(i == `TAP_IR_WIDTH - 1, code[i]);
        end
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
        wait_checker_done();
    endtask

    // Idle to Shift-DR, shift nbits, back to Idle
    task automatic scan_dr(input int nbits, input logic [63:0] bits);
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);
        for (int i = 0; i < nbits; i++) begin
            step(i == nbits - 1, bits[i]);
        end
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
    endtask

    // Leave a DR shift midway with five TMS-high cycles
    task automatic reset_from_shift(input logic [255:0] name);
        arm_checker(name, 0, 64'h0, 1'b0);
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            step(1'b0, 1'b1);
        end
        for (int i = 0; i < 5; i++) begin
            step(1'b1, 1'b0);
        end
        step(1'b0, 1'b0);                 // Test-Logic-Reset to Run-Test/Idle
        wait_checker_done();
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int           fd;
        int           n;
        int           nbits;
        int           cap0;
        int           upd0;
        int           sft0;
        string        line;
        logic [255:0] name;
        logic [255:0] op;
        logic [63:0]  tdi_v;
        logic [63:0]  exp_v;
        logic [4:0]   code;
        logic         exp_sel;
        logic [1:0]   exp_id;

        tck         = 1'b0;
        trst_n      = 1'b0;
        tms         = 1'b1;
        tdi         = 1'b0;
        fuse_idcode = 32'hDEAD_C0DE;
        chk_start   = 1'b0;
        chk_en      = 1'b0;
        chk_len     = '0;
        chk_exp     = '0;
        chk_name    = "reset";
        tb_errors   = 0;
        cap_cnt     = 0;
        upd_cnt     = 0;
        sft_cnt     = 0;

        repeat (2) @(posedge tck);
        @(negedge tck);
        compare_value("reset", "tdo", 64'h0, {63'h0, tdo});
        compare_value("reset", "tdo_en", 64'h0, {63'h0, tdo_en});
        compare_value("reset", "chain strobes", 64'h0,
                      {61'h0, dmi_chain.capture, dmi_chain.shift, dmi_chain.update});
        @(posedge tck);
        trst_n <= 1'b1;
        step(1'b0, 1'b0);                 // Into Run-Test/Idle

        fd = $fopen("tests/tap_input.txt", "r");
        if (fd == 0) end_with_failure("Cannot open tests/tap_input.txt");

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line.getc(0) == "#") continue;
            if ($sscanf(line, "%s %s %d %h %h", name, op, nbits, tdi_v, exp_v) != 5) begin
                $display("Bad line in tests/tap_input.txt: %s", line);
                tb_errors++;
                continue;
            end
            code = `TAP_INSTR_IDCODE;      // IR default when nothing is loaded
            if (op == "r") begin
                reset_from_shift(name);
            end else if (op != "-") begin
                n = $sscanf(op, "%h", code);
                load_instruction(name, code);
            end

            cap0 = cap_cnt;
            upd0 = upd_cnt;
            sft0 = sft_cnt;
            arm_checker(name, nbits, exp_v, 1'b1);

            // IR hold has loaded on an earlier falling edge by now
            exp_sel = (code == `TAP_INSTR_DTMCS) || (code == `TAP_INSTR_DMI_ACCESS);
            exp_id  = (code == `TAP_INSTR_DTMCS) ? 2'd1 :
                      (code == `TAP_INSTR_DMI_ACCESS) ? 2'd2 : 2'd0;
            compare_value(name, "chain sel", {63'h0, exp_sel}, {63'h0, dmi_chain.sel});
            if (exp_sel) compare_value(name, "chain id", {62'h0, exp_id}, {62'h0, dmi_chain.id});

            scan_dr(nbits, tdi_v);
            wait_checker_done();
            @(posedge tck);                // Update-DR strobe counted on the edge before
            compare_value(name, "capture pulses", 64'd1, 64'(cap_cnt - cap0));
            compare_value(name, "update pulses", 64'd1, 64'(upd_cnt - upd0));
            compare_value(name, "shift cycles", 64'(nbits), 64'(sft_cnt - sft0));
        end
        $fclose(fd);

        repeat (2) @(posedge tck);
        $display("Errors: %0d (testbench %0d, checker %0d)",
                 tb_errors + chk_errors, tb_errors, chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tap_tb

`default_nettype wire
